// ==== common/fb_host_pkg.sv ====
package fb_host_pkg;

	localparam int REG_ADDR_W  = 2;
	localparam int HOST_DATA_W = 32;
	localparam int READ_DATA_W = 16;

	typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
	typedef logic [HOST_DATA_W-1:0] host_data_t;
	typedef logic [READ_DATA_W-1:0] read_data_t;

	// Word addresses on the Avalon-MM slave port
	localparam reg_addr_t REG_STATUS = 2'd0;
	localparam reg_addr_t REG_ADDR   = 2'd1;
	localparam reg_addr_t REG_WBUF   = 2'd2;

	// Status register layout
	localparam int STS_INIT_BIT = 0;
	localparam int STS_IDLE_BIT = 1;
	localparam read_data_t STATUS_RESET = 16'h0002;

	typedef enum logic {
		REQ_ADDR = 1'b0,
		REQ_DATA = 1'b1
	} req_kind_t;

	typedef struct packed {
		logic                 valid;
		req_kind_t            kind;
		gram_pkg::gram_addr_t addr;
		gram_pkg::gram_data_t data;
	} host_req_t;

endpackage

// ==== common/gram_pkg.sv ====
package gram_pkg;

	localparam int GRAM_ADDR_W = 17;
	localparam int GRAM_DATA_W = 16;

	typedef logic [GRAM_ADDR_W-1:0] gram_addr_t;
	typedef logic [GRAM_DATA_W-1:0] gram_data_t;

	// Highest word address before the counter wraps to zero
	localparam gram_addr_t GRAM_ADDR_LAST = {GRAM_ADDR_W{1'b1}};

	// One command from the sequencer to the RAM port
	typedef struct packed {
		logic       valid;
		logic       ref_addr;   // Load the address counter instead of writing
		gram_addr_t addr;
		gram_data_t data;
	} gram_cmd_t;

	// External write bus towards the graphics RAM
	typedef struct packed {
		logic       we;
		gram_addr_t addr;
		gram_data_t data;
	} gram_wr_t;

endpackage

// ==== fb_writer.f ====
common/gram_pkg.sv
common/fb_host_pkg.sv
hdl/fb_host_regs.sv
hdl/fb_write_seq.sv
hdl/gram_port.sv
hdl/fb_writer_top.sv
tests/fb_writer_asserts.sv
tests/fb_writer_tb.sv

// ==== hdl/fb_host_regs.sv ====
`timescale 1ns/1ps

module fb_host_regs (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    read,
	input  logic                    write,
	input  fb_host_pkg::reg_addr_t  address,
	input  fb_host_pkg::host_data_t writedata,
	output fb_host_pkg::read_data_t readdata,
	input  logic                    init_done,
	input  logic                    busy,
	input  logic                    done,
	output fb_host_pkg::host_req_t  req
);
	import fb_host_pkg::*;
	import gram_pkg::*;

	read_data_t status;
	gram_addr_t addr_ptr;
	gram_data_t wr_buffer;
	logic       req_valid;
	req_kind_t  req_kind;
	logic       accept;
	logic       wr_addr_hit;
	logic       wr_data_hit;
	logic       issue;

	// The pending request counts as busy until the sequencer has taken it
	assign accept      = !busy && !req_valid;
	assign wr_addr_hit = write && (address == REG_ADDR) && accept;
	assign wr_data_hit = write && (address == REG_WBUF) && accept;
	assign issue       = wr_addr_hit || wr_data_hit;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			addr_ptr  <= '0;
			wr_buffer <= '0;
		end
		else
		begin
			if (wr_addr_hit)
				addr_ptr <= writedata[GRAM_ADDR_W-1:0];
			if (wr_data_hit)
				wr_buffer <= writedata[GRAM_DATA_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			req_valid <= 1'b0;
			req_kind  <= REQ_ADDR;
		end
		else
		begin
			req_valid <= issue;  // Single-cycle pulse
			if (wr_addr_hit)
				req_kind <= REQ_ADDR;
			else if (wr_data_hit)
				req_kind <= REQ_DATA;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			status <= STATUS_RESET;
		else
		begin
			status[STS_INIT_BIT] <= init_done;
			// A new request wins over a completion in the same cycle
			if (issue)
				status[STS_IDLE_BIT] <= 1'b0;
			else if (done)
				status[STS_IDLE_BIT] <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			readdata <= '0;
		else if (read)
		begin
			case (address)
				REG_STATUS: readdata <= status;
				REG_WBUF:   readdata <= wr_buffer;
				default:    ;  // Pointer and unused address keep the last value
			endcase
		end
	end

	assign req = '{valid: req_valid, kind: req_kind, addr: addr_ptr, data: wr_buffer};

endmodule

// ==== hdl/fb_write_seq.sv ====
`timescale 1ns/1ps

module fb_write_seq (
	input  logic                   clk,
	input  logic                   reset_n,
	input  fb_host_pkg::host_req_t req,
	output gram_pkg::gram_cmd_t    cmd,
	input  logic                   wr_able,
	output logic                   busy,
	output logic                   done
);
	import fb_host_pkg::*;
	import gram_pkg::*;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ISSUE,
		SEQ_WAIT
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_next;
	logic       cmd_ref;
	gram_addr_t cmd_addr;
	gram_data_t cmd_data;
	logic       take_req;

	assign take_req = (state == SEQ_IDLE) && req.valid;

	always_comb
	begin
		state_next = state;
		case (state)
			SEQ_IDLE:
			begin
				if (req.valid)
					state_next = SEQ_ISSUE;
			end
			SEQ_ISSUE:
				state_next = SEQ_WAIT;  // Command is on the bus for exactly one cycle
			SEQ_WAIT:
			begin
				if (wr_able)
					state_next = SEQ_IDLE;
			end
			default:
				state_next = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= SEQ_IDLE;
			done  <= 1'b0;
		end
		else
		begin
			state <= state_next;
			done  <= (state == SEQ_WAIT) && wr_able;
		end
	end

	// Command payload is captured with the request
	always_ff @(posedge clk)
	begin
		if (take_req)
		begin
			cmd_ref  <= (req.kind == REQ_ADDR);
			cmd_addr <= req.addr;
			cmd_data <= req.data;
		end
	end

	assign busy = (state != SEQ_IDLE);
	assign cmd  = '{
		valid:    (state == SEQ_ISSUE),
		ref_addr: cmd_ref,
		addr:     cmd_addr,
		data:     cmd_data
	};

endmodule

// ==== hdl/fb_writer_top.sv ====
`timescale 1ns/1ps

module fb_writer_top (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    read,
	input  logic                    write,
	input  fb_host_pkg::reg_addr_t  address,
	input  fb_host_pkg::host_data_t writedata,
	output fb_host_pkg::read_data_t readdata,
	input  logic                    init_done,
	output gram_pkg::gram_wr_t      ram_wr,
	input  logic                    ram_ack
);
	import fb_host_pkg::*;
	import gram_pkg::*;

	host_req_t req;
	gram_cmd_t cmd;
	logic      busy;
	logic      done;
	logic      wr_able;

	fb_host_regs u_host_regs (
		.clk       (clk),
		.reset_n   (reset_n),
		.read      (read),
		.write     (write),
		.address   (address),
		.writedata (writedata),
		.readdata  (readdata),
		.init_done (init_done),
		.busy      (busy),
		.done      (done),
		.req       (req)
	);

	fb_write_seq u_write_seq (
		.clk     (clk),
		.reset_n (reset_n),
		.req     (req),
		.cmd     (cmd),
		.wr_able (wr_able),
		.busy    (busy),
		.done    (done)
	);

	gram_port u_gram_port (
		.clk     (clk),
		.reset_n (reset_n),
		.cmd     (cmd),
		.wr_able (wr_able),
		.ram_wr  (ram_wr),
		.ram_ack (ram_ack)
	);

endmodule

// ==== hdl/gram_port.sv ====
`timescale 1ns/1ps

module gram_port (
	input  logic                clk,
	input  logic                reset_n,
	input  gram_pkg::gram_cmd_t cmd,
	output logic                wr_able,
	output gram_pkg::gram_wr_t  ram_wr,
	input  logic                ram_ack
);
	import gram_pkg::*;

	gram_addr_t addr_cnt;
	gram_addr_t addr_inc;
	gram_data_t wr_data;
	logic       we;
	logic       ack_taken;
	logic       load_cmd;
	logic       data_cmd;

	assign load_cmd  = cmd.valid && cmd.ref_addr;
	assign data_cmd  = cmd.valid && !cmd.ref_addr;
	assign ack_taken = we && ram_ack;

	// Next word address wraps to zero at the top of the RAM
	assign addr_inc = (addr_cnt == GRAM_ADDR_LAST) ? '0 : addr_cnt + 17'd1;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			addr_cnt <= '0;
			we       <= 1'b0;
			wr_able  <= 1'b0;
		end
		else
		begin
			wr_able <= 1'b0;

			if (load_cmd)
			begin
				addr_cnt <= cmd.addr;
				wr_able  <= 1'b1;
			end
			else if (data_cmd)
				we <= 1'b1;

			// Write is taken in the ack cycle and we drops at the next edge
			if (ack_taken)
			begin
				we       <= 1'b0;
				wr_able  <= 1'b1;
				addr_cnt <= addr_inc;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (data_cmd)
			wr_data <= cmd.data;
	end

	// Address comes straight from the counter, which only moves after the ack
	assign ram_wr = '{we: we, addr: addr_cnt, data: wr_data};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
	--top-module fb_writer_tb -Mdir obj_dir -f fb_writer.f &&
	./obj_dir/Vfb_writer_tb | tee /dev/stderr | grep -q "^NO ERRORS$" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// ==== tests/fb_writer_asserts.sv ====
`timescale 1ns/1ps

module fb_writer_asserts (
	input logic                clk,
	input logic                reset_n,
	input gram_pkg::gram_cmd_t cmd,
	input logic                wr_able,
	input gram_pkg::gram_wr_t  ram_wr,
	input logic                ram_ack
);

	// A pending write keeps we, address and data until the RAM acks it
	held_write: assert property (@(posedge clk) disable iff (!reset_n)
		ram_wr.we && !ram_ack |=> $stable(ram_wr))
		else $error("ram_wr changed while the write was still pending");

	single_wr_able: assert property (@(posedge clk) disable iff (!reset_n)
		wr_able |=> !wr_able)
		else $error("wr_able was high for two cycles in a row");

	// Only one command may be outstanding
	no_cmd_overlap: assert property (@(posedge clk) disable iff (!reset_n)
		cmd.valid |-> !ram_wr.we)
		else $error("command arrived while a RAM write was pending");

endmodule

bind gram_port fb_writer_asserts u_asserts (
	.clk     (clk),
	.reset_n (reset_n),
	.cmd     (cmd),
	.wr_able (wr_able),
	.ram_wr  (ram_wr),
	.ram_ack (ram_ack)
);

// ==== tests/fb_writer_tb.sv ====
`timescale 1ns/1ps

module fb_writer_tb;
	import fb_host_pkg::*;
	import gram_pkg::*;

	logic       clk;
	logic       reset_n;
	logic       read;
	logic       write;
	reg_addr_t  address;
	host_data_t writedata;
	read_data_t readdata;
	logic       init_done;
	gram_wr_t   ram_wr;
	logic       ram_ack;

	integer     seed = 32'h694a16a0;
	int         ack_delay;
	logic       ack_hold;
	int         wait_count;
	int         errors;
	gram_addr_t wr_addr_q[$];  // Writes taken by the RAM model in order
	gram_data_t wr_data_q[$];

	fb_writer_top u_fb_writer_top (
		.clk       (clk),
		.reset_n   (reset_n),
		.read      (read),
		.write     (write),
		.address   (address),
		.writedata (writedata),
		.readdata  (readdata),
		.init_done (init_done),
		.ram_wr    (ram_wr),
		.ram_ack   (ram_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// RAM model acks a pending write after ack_delay cycles unless held off
	initial
	begin
		ram_ack    = 1'b0;
		wait_count = 0;
		forever
		begin
			@(negedge clk);
			if (ram_wr.we && !ram_ack && !ack_hold && wait_count >= ack_delay)
			begin
				ram_ack = 1'b1;
				wr_addr_q.push_back(ram_wr.addr);
				wr_data_q.push_back(ram_wr.data);
			end
			else
			begin
				ram_ack = 1'b0;
				if (ram_wr.we)
					wait_count++;
				else
					wait_count = 0;
			end
		end
	end

	task automatic fail_run(input string msg);
		errors++;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic host_write(input reg_addr_t addr, input host_data_t data);
		@(negedge clk);
		write     = 1'b1;
		address   = addr;
		writedata = data;
		@(negedge clk);
		write = 1'b0;
	endtask

	// Read latency is one cycle, so the data is settled at the next falling edge
	task automatic host_read(input reg_addr_t addr, output read_data_t data);
		@(negedge clk);
		read    = 1'b1;
		address = addr;
		@(negedge clk);
		read = 1'b0;
		data = readdata;
	endtask

	task automatic check_read(input reg_addr_t addr, input read_data_t exp);
		read_data_t got;
		host_read(addr, got);
		if (got !== exp)
			fail_run($sformatf("mismatch readdata (address %0d): got 0x%04h expected 0x%04h",
				addr, got, exp));
	endtask

	task automatic check_ram_write(input gram_addr_t exp_addr, input gram_data_t exp_data);
		gram_addr_t got_addr;
		gram_data_t got_data;
		if (wr_addr_q.size() == 0)
			fail_run("expected a RAM write, but none was accepted");
		else
		begin
			got_addr = wr_addr_q.pop_front();
			got_data = wr_data_q.pop_front();
			if (got_addr !== exp_addr)
				fail_run($sformatf("mismatch ram_wr.addr: got 0x%05h expected 0x%05h",
					got_addr, exp_addr));
			else if (got_data !== exp_data)
				fail_run($sformatf("mismatch ram_wr.data: got 0x%04h expected 0x%04h",
					got_data, exp_data));
		end
	endtask

	task automatic expect_no_more_writes();
		if (wr_addr_q.size() != 0)
			fail_run("the RAM port made a write that was not expected");
	endtask

	// Polls status until the idle bit is set
	task automatic wait_idle();
		read_data_t sts;
		int         polls;
		polls = 0;
		host_read(REG_STATUS, sts);
		while (!sts[STS_IDLE_BIT])
		begin
			polls++;
			if (polls > 200)
				fail_run("timeout while waiting for the bridge to become idle");
			else
				host_read(REG_STATUS, sts);
		end
	endtask

	task automatic wait_write_pending();
		int cycles;
		cycles = 0;
		while (!ram_wr.we)
		begin
			cycles++;
			if (cycles > 50)
				fail_run("timeout while waiting for a write on the RAM port");
			else
				@(negedge clk);
		end
	endtask

	task automatic test_reset_status();
		check_read(REG_STATUS, 16'h0002);
		check_read(REG_WBUF, 16'h0000);
		@(negedge clk);
		init_done = 1'b1;
		check_read(REG_STATUS, 16'h0003);
	endtask

	task automatic test_single_write();
		ack_delay = 0;
		host_write(REG_ADDR, 32'h0000_0A5C);
		wait_idle();
		host_write(REG_WBUF, 32'h0000_BEEF);
		wait_idle();
		check_ram_write(17'h00A5C, 16'hBEEF);
		expect_no_more_writes();
	endtask

	task automatic test_burst_and_wrap();
		gram_data_t d;
		ack_delay = 1;
		host_write(REG_ADDR, 32'hFFFE_1230);  // Upper bits are not part of the pointer
		wait_idle();
		for (int i = 0; i < 4; i++)
		begin
			d = 16'h1000 + 16'(i) * 16'h0111;
			host_write(REG_WBUF, {16'hFFFF, d});
			wait_idle();
		end
		for (int i = 0; i < 4; i++)
			check_ram_write(17'h01230 + 17'(i), 16'h1000 + 16'(i) * 16'h0111);
		host_write(REG_ADDR, 32'h0001_FFFF);
		wait_idle();
		host_write(REG_WBUF, 32'h0000_A001);
		wait_idle();
		host_write(REG_WBUF, 32'h0000_A002);
		wait_idle();
		check_ram_write(17'h1FFFF, 16'hA001);
		check_ram_write(17'h00000, 16'hA002);
		expect_no_more_writes();
	endtask

	task automatic test_ack_backpressure();
		host_write(REG_ADDR, 32'h0000_0800);
		wait_idle();
		for (int i = 0; i < 3; i++)
		begin
			ack_delay = 5 + ($unsigned($random(seed)) % 16);
			host_write(REG_WBUF, 32'h0000_6000 + 32'(i));
			check_read(REG_STATUS, 16'h0001);
			check_read(REG_STATUS, 16'h0001);
			wait_idle();
			check_read(REG_STATUS, 16'h0003);
			check_ram_write(17'h00800 + 17'(i), 16'h6000 + 16'(i));
		end
		expect_no_more_writes();
	endtask

	task automatic test_busy_drop();
		ack_delay = 0;
		host_write(REG_ADDR, 32'h0000_0040);
		wait_idle();
		host_write(REG_WBUF, 32'h0000_5A5A);
		wait_idle();
		check_ram_write(17'h00040, 16'h5A5A);
		check_read(REG_WBUF, 16'h5A5A);
		ack_hold = 1'b1;
		host_write(REG_WBUF, 32'h0000_C3C3);
		wait_write_pending();
		host_write(REG_WBUF, 32'h0000_7777);  // Bridge is busy, so this one is dropped
		check_read(REG_WBUF, 16'hC3C3);
		ack_hold = 1'b0;
		wait_idle();
		check_ram_write(17'h00041, 16'hC3C3);
		expect_no_more_writes();
		check_read(REG_WBUF, 16'hC3C3);
	endtask

	initial
	begin
		reset_n   = 1'b0;
		read      = 1'b0;
		write     = 1'b0;
		address   = '0;
		writedata = '0;
		init_done = 1'b0;
		ack_delay = 0;
		ack_hold  = 1'b0;
		errors    = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		test_reset_status();
		test_single_write();
		test_burst_and_wrap();
		test_ack_backpressure();
		test_busy_drop();
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
